// File: design/stream_demux_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream demux package
// Beat field types, the drop count type, the route
// state encoding and the default output counts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package stream_demux_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Beat fields
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [7:0] data_t;                  // Payload of one beat
    typedef logic [2:0] dest_t;                  // Values 0 to 3 map to outputs, 4 to 7 drop

    typedef logic [7:0] count_t;                 // Dropped packets, saturates at 255

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Route FSM states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic {
        ROUTE_IDLE,                              // Waiting for the first beat of a packet
        ROUTE_PACKET                             // Inside a packet, destination locked
    } route_state_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Default sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int TOTAL_OUTPUTS = 4;            // Mapped outputs over the whole chain
    localparam int UNIT_OUTPUTS  = 2;            // Mapped outputs of the first unit

endpackage

// File: design/stream_route_fsm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream route FSM
// Locks the destination of each packet from its
// first beat until its last beat
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module stream_route_fsm (
    input  logic                    aclk,
    input  logic                    areset_n,
    input  logic                    in_tvalid,
    input  stream_demux_pkg::data_t in_tdata,
    input  stream_demux_pkg::dest_t in_tdest,
    input  logic                    in_tlast,
    output logic                    in_tready,
    output logic                    route_tvalid,
    output stream_demux_pkg::data_t route_tdata,
    output stream_demux_pkg::dest_t route_tdest,
    output logic                    route_tlast,
    input  logic                    route_tready
);
    import stream_demux_pkg::*;

    route_state_t state;
    dest_t        dest_lock;                     // Destination taken from the first beat
    logic         xfer;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pass-through path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign route_tvalid = in_tvalid;
    assign route_tdata  = in_tdata;
    assign route_tlast  = in_tlast;
    assign in_tready    = route_tready;

    assign xfer = in_tvalid && in_tready;

    // Later beats ignore whatever in_tdest shows
    assign route_tdest = (state == ROUTE_PACKET) ? dest_lock : in_tdest;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            state <= ROUTE_IDLE;
        end else begin
            case (state)
                ROUTE_IDLE: begin
                    if (xfer && !in_tlast) begin
                        state <= ROUTE_PACKET;   // Single-beat packets stay idle
                    end
                end
                ROUTE_PACKET: begin
                    if (xfer && in_tlast) begin
                        state <= ROUTE_IDLE;
                    end
                end
                default: state <= ROUTE_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (state == ROUTE_IDLE && xfer && !in_tlast) begin
            dest_lock <= in_tdest;               // Captured on the first beat only
        end
    end

    // A stalled beat keeps its payload and its effective route
    a_beat_stable: assert property (
        @(posedge aclk) disable iff (!areset_n)
        (in_tvalid && !in_tready) |=> (in_tvalid && $stable(in_tdata) &&
                                       $stable(in_tlast) && $stable(route_tdest))
    );

endmodule

// File: design/stream_demux_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream demux unit
// Registered stage that steers each beat to one of
// a block of mapped outputs or to a pass-on output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module stream_demux_unit #(
    parameter int OUTPUTS   = 2,                 // Mapped outputs of this stage
    parameter int BASE_DEST = 0                  // First destination mapped here
) (
    input  logic                                  aclk,
    input  logic                                  areset_n,
    input  logic                                  in_tvalid,
    input  stream_demux_pkg::data_t               in_tdata,
    input  stream_demux_pkg::dest_t               in_tdest,
    input  logic                                  in_tlast,
    output logic                                  in_tready,
    output logic                    [OUTPUTS-1:0] out_tvalid,
    output stream_demux_pkg::data_t [OUTPUTS-1:0] out_tdata,
    output stream_demux_pkg::dest_t [OUTPUTS-1:0] out_tdest,
    output logic                    [OUTPUTS-1:0] out_tlast,
    input  logic                    [OUTPUTS-1:0] out_tready,
    output logic                                  next_tvalid,
    output stream_demux_pkg::data_t               next_tdata,
    output stream_demux_pkg::dest_t               next_tdest,
    output logic                                  next_tlast,
    input  logic                                  next_tready
);
    import stream_demux_pkg::*;

    // Lanes 0 to OUTPUTS-1 are the mapped outputs, the top lane passes on
    localparam int SELECT = OUTPUTS + 1;

    logic  [SELECT-1:0] select;
    logic  [SELECT-1:0] ready;

    logic  [SELECT-1:0] valid_q;
    data_t [SELECT-1:0] data_q;
    dest_t [SELECT-1:0] dest_q;
    logic  [SELECT-1:0] last_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        select = '0;
        for (int i = 0; i < OUTPUTS; i++) begin
            select[i] = (in_tdest == dest_t'(BASE_DEST + i));
        end
        select[OUTPUTS] = ~|select[OUTPUTS-1:0];  // Unmapped beats go on
    end

    assign ready = {next_tready, out_tready};

    // Stall only when the selected lane is blocked
    assign in_tready = !in_tvalid || |(ready & select);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lane registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            valid_q <= '0;
        end else begin
            for (int k = 0; k < SELECT; k++) begin
                if (ready[k]) begin
                    valid_q[k] <= in_tvalid && select[k];  // Clears after a transfer
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        for (int k = 0; k < SELECT; k++) begin
            if (ready[k]) begin
                data_q[k] <= in_tdata;
                dest_q[k] <= in_tdest;
                last_q[k] <= in_tlast;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output ports
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign out_tvalid = valid_q[OUTPUTS-1:0];
    assign out_tdata  = data_q[OUTPUTS-1:0];
    assign out_tdest  = dest_q[OUTPUTS-1:0];
    assign out_tlast  = last_q[OUTPUTS-1:0];

    assign next_tvalid = valid_q[OUTPUTS];
    assign next_tdata  = data_q[OUTPUTS];
    assign next_tdest  = dest_q[OUTPUTS];
    assign next_tlast  = last_q[OUTPUTS];

    // A waiting beat keeps its lane until it is taken
    a_select_held: assert property (
        @(posedge aclk) disable iff (!areset_n)
        (in_tvalid && !in_tready) |=> (in_tvalid && $stable(select))
    );

endmodule

// File: design/stream_drop_counter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream drop counter
// Sinks unmapped packets and counts them, saturating
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module stream_drop_counter (
    input  logic                     aclk,
    input  logic                     areset_n,
    input  logic                     drop_tvalid,
    input  logic                     drop_tlast,
    output logic                     drop_tready,
    output stream_demux_pkg::count_t drop_count
);
    import stream_demux_pkg::*;

    localparam count_t COUNT_MAX = '1;

    logic packet_done;

    assign drop_tready = 1'b1;                   // The sink never stalls

    // One packet ends per accepted last beat
    assign packet_done = drop_tvalid && drop_tready && drop_tlast;

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            drop_count <= '0;
        end else if (packet_done && drop_count != COUNT_MAX) begin
            drop_count <= drop_count + 1'b1;     // Holds at the maximum
        end
    end

    // Saturation means the count only moves upward
    a_count_monotonic: assert property (
        @(posedge aclk) disable iff (!areset_n)
        drop_count >= $past(drop_count)
    );

endmodule

// File: design/stream_demux_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream demux top
// Route FSM, two chained demux units and the drop
// counter behind the last unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module stream_demux_top #(
    parameter int TOTAL_OUTPUTS = stream_demux_pkg::TOTAL_OUTPUTS,
    parameter int UNIT_OUTPUTS  = stream_demux_pkg::UNIT_OUTPUTS
) (
    input  logic                                        aclk,
    input  logic                                        areset_n,
    input  logic                                        in_tvalid,
    input  stream_demux_pkg::data_t                     in_tdata,
    input  stream_demux_pkg::dest_t                     in_tdest,
    input  logic                                        in_tlast,
    output logic                                        in_tready,
    output logic                    [TOTAL_OUTPUTS-1:0] out_tvalid,
    output stream_demux_pkg::data_t [TOTAL_OUTPUTS-1:0] out_tdata,
    output stream_demux_pkg::dest_t [TOTAL_OUTPUTS-1:0] out_tdest,
    output logic                    [TOTAL_OUTPUTS-1:0] out_tlast,
    input  logic                    [TOTAL_OUTPUTS-1:0] out_tready,
    output stream_demux_pkg::count_t                    drop_count
);
    import stream_demux_pkg::*;

    // Route FSM to unit 0
    logic  route_tvalid;
    data_t route_tdata;
    dest_t route_tdest;
    logic  route_tlast;
    logic  route_tready;

    // Unit 0 pass-on to unit 1
    logic  mid_tvalid;
    data_t mid_tdata;
    dest_t mid_tdest;
    logic  mid_tlast;
    logic  mid_tready;

    // Unit 1 pass-on to the drop counter
    logic  drop_tvalid;
    logic  drop_tlast;
    logic  drop_tready;

    stream_route_fsm stream_route_fsm_i (
        .aclk         (aclk),
        .areset_n     (areset_n),
        .in_tvalid    (in_tvalid),
        .in_tdata     (in_tdata),
        .in_tdest     (in_tdest),
        .in_tlast     (in_tlast),
        .in_tready    (in_tready),
        .route_tvalid (route_tvalid),
        .route_tdata  (route_tdata),
        .route_tdest  (route_tdest),
        .route_tlast  (route_tlast),
        .route_tready (route_tready)
    );

    stream_demux_unit #(
        .OUTPUTS   (UNIT_OUTPUTS),
        .BASE_DEST (0)
    ) stream_demux_unit_0_i (
        .aclk        (aclk),
        .areset_n    (areset_n),
        .in_tvalid   (route_tvalid),
        .in_tdata    (route_tdata),
        .in_tdest    (route_tdest),
        .in_tlast    (route_tlast),
        .in_tready   (route_tready),
        .out_tvalid  (out_tvalid[UNIT_OUTPUTS-1:0]),
        .out_tdata   (out_tdata[UNIT_OUTPUTS-1:0]),
        .out_tdest   (out_tdest[UNIT_OUTPUTS-1:0]),
        .out_tlast   (out_tlast[UNIT_OUTPUTS-1:0]),
        .out_tready  (out_tready[UNIT_OUTPUTS-1:0]),
        .next_tvalid (mid_tvalid),
        .next_tdata  (mid_tdata),
        .next_tdest  (mid_tdest),
        .next_tlast  (mid_tlast),
        .next_tready (mid_tready)
    );

    stream_demux_unit #(
        .OUTPUTS   (TOTAL_OUTPUTS - UNIT_OUTPUTS),
        .BASE_DEST (UNIT_OUTPUTS)
    ) stream_demux_unit_1_i (
        .aclk        (aclk),
        .areset_n    (areset_n),
        .in_tvalid   (mid_tvalid),
        .in_tdata    (mid_tdata),
        .in_tdest    (mid_tdest),
        .in_tlast    (mid_tlast),
        .in_tready   (mid_tready),
        .out_tvalid  (out_tvalid[TOTAL_OUTPUTS-1:UNIT_OUTPUTS]),
        .out_tdata   (out_tdata[TOTAL_OUTPUTS-1:UNIT_OUTPUTS]),
        .out_tdest   (out_tdest[TOTAL_OUTPUTS-1:UNIT_OUTPUTS]),
        .out_tlast   (out_tlast[TOTAL_OUTPUTS-1:UNIT_OUTPUTS]),
        .out_tready  (out_tready[TOTAL_OUTPUTS-1:UNIT_OUTPUTS]),
        .next_tvalid (drop_tvalid),
        .next_tdata  (),                         // Dropped payload goes nowhere
        .next_tdest  (),
        .next_tlast  (drop_tlast),
        .next_tready (drop_tready)
    );

    stream_drop_counter stream_drop_counter_i (
        .aclk        (aclk),
        .areset_n    (areset_n),
        .drop_tvalid (drop_tvalid),
        .drop_tlast  (drop_tlast),
        .drop_tready (drop_tready),
        .drop_count  (drop_count)
    );

endmodule

// File: bench/stream_demux_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream demux testbench
// Table-driven packets with random back-pressure,
// per-output scoreboards and the drop count check
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module stream_demux_tb;
    import stream_demux_pkg::*;

    localparam int PACKETS = 12;
    localparam int OUTS    = TOTAL_OUTPUTS;

    logic             aclk       = 1'b0;
    logic             areset_n   = 1'b0;
    logic             in_tvalid  = 1'b0;
    data_t            in_tdata   = '0;
    dest_t            in_tdest   = '0;
    logic             in_tlast   = 1'b0;
    logic             in_tready;
    logic  [OUTS-1:0] out_tvalid;
    data_t [OUTS-1:0] out_tdata;
    dest_t [OUTS-1:0] out_tdest;
    logic  [OUTS-1:0] out_tlast;
    logic  [OUTS-1:0] out_tready = '0;
    count_t           drop_count;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Packet table, one column per field
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    dest_t tbl_dest [PACKETS] = '{3'd0, 3'd1, 3'd5, 3'd2, 3'd3, 3'd0,
                                  3'd6, 3'd3, 3'd1, 3'd4, 3'd2, 3'd7};
    int    tbl_len  [PACKETS] = '{4, 1, 3, 2, 4, 3, 1, 1, 2, 4, 3, 2};
    data_t tbl_data [PACKETS] = '{8'h10, 8'h20, 8'h30, 8'h40, 8'h50, 8'h60,
                                  8'h70, 8'h80, 8'h90, 8'ha0, 8'hb0, 8'hfe};

    data_t exp_data [OUTS][$];                   // Expected beats per output, in order
    logic  exp_last [OUTS][$];

    logic  [OUTS-1:0] stalled = '0;              // Lane held valid with ready low last cycle
    data_t held_data [OUTS];
    dest_t held_dest [OUTS];
    logic  held_last [OUTS];

    int seed        = 32'h40b;
    int cycles      = 0;
    int cycle_limit = 0;

    stream_demux_top stream_demux_top_i (
        .aclk       (aclk),
        .areset_n   (areset_n),
        .in_tvalid  (in_tvalid),
        .in_tdata   (in_tdata),
        .in_tdest   (in_tdest),
        .in_tlast   (in_tlast),
        .in_tready  (in_tready),
        .out_tvalid (out_tvalid),
        .out_tdata  (out_tdata),
        .out_tdest  (out_tdest),
        .out_tlast  (out_tlast),
        .out_tready (out_tready),
        .drop_count (drop_count)
    );

    always #20 aclk = ~aclk;                     // 40 ns period

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Failure and compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR t=%0t %s expected %0h actual %0h", $time, name, exp, act));
        end
    endtask

    task automatic check_dest(input string name, input dest_t exp, input dest_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR t=%0t %s expected %0d actual %0d", $time, name, exp, act));
        end
    endtask

    task automatic check_last(input string name, input bit exp, input bit act);
        if (act !== exp) begin
            abort_run($sformatf("ERR t=%0t %s expected %0b actual %0b", $time, name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input count_t exp, input count_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR t=%0t %s expected %0d actual %0d", $time, name, exp, act));
        end
    endtask

    function automatic bit outputs_drained();
        for (int k = 0; k < OUTS; k++) begin
            if (exp_data[k].size() != 0) return 1'b0;
        end
        return 1'b1;
    endfunction

    // Holds the beat until the DUT takes it, then returns on the next falling edge
    task automatic send_beat(input data_t data, input dest_t dest, input logic last);
        in_tvalid = 1'b1;
        in_tdata  = data;
        in_tdest  = dest;
        in_tlast  = last;
        #1;
        while (!in_tready) begin
            @(negedge aclk);
            #1;
        end
        @(negedge aclk);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Back-pressure, output scoreboards and timeout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge aclk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            abort_run($sformatf("Timeout after %0d cycles with beats still pending", cycles));
        end
        out_tready = OUTS'($random(seed));       // Registered outputs are stable here
        for (int k = 0; k < OUTS; k++) begin
            if (areset_n && stalled[k]) begin
                check_last($sformatf("out_tvalid[%0d]", k), 1'b1, out_tvalid[k]);
                check_data($sformatf("out_tdata[%0d]", k), held_data[k], out_tdata[k]);
                check_dest($sformatf("out_tdest[%0d]", k), held_dest[k], out_tdest[k]);
                check_last($sformatf("out_tlast[%0d]", k), held_last[k], out_tlast[k]);
            end
            if (areset_n && out_tvalid[k] && out_tready[k]) begin
                if (exp_data[k].size() == 0) begin
                    abort_run($sformatf("Unexpected beat on output %0d at %0t", k, $time));
                end else begin
                    check_data($sformatf("out_tdata[%0d]", k), exp_data[k][0], out_tdata[k]);
                    check_dest($sformatf("out_tdest[%0d]", k), dest_t'(k), out_tdest[k]);
                    check_last($sformatf("out_tlast[%0d]", k), exp_last[k][0], out_tlast[k]);
                    void'(exp_data[k].pop_front());
                    void'(exp_last[k].pop_front());
                end
            end
            stalled[k]   = areset_n && out_tvalid[k] && !out_tready[k];
            held_data[k] = out_tdata[k];
            held_dest[k] = out_tdest[k];
            held_last[k] = out_tlast[k];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        count_t exp_drops;
        int     total_beats;
        exp_drops   = '0;
        total_beats = 0;
        for (int p = 0; p < PACKETS; p++) begin
            total_beats = total_beats + tbl_len[p];
            if (tbl_dest[p] < 3'd4) begin        // Mapped output is the first-beat destination
                for (int b = 0; b < tbl_len[p]; b++) begin
                    exp_data[tbl_dest[p]].push_back(tbl_data[p] + data_t'(b));
                    exp_last[tbl_dest[p]].push_back(b == tbl_len[p] - 1);
                end
            end else begin
                exp_drops = exp_drops + count_t'(1);
            end
        end
        cycle_limit = 40 * total_beats;

        repeat (5) @(posedge aclk);
        @(negedge aclk);
        areset_n = 1'b1;
        for (int k = 0; k < OUTS; k++) begin
            check_last($sformatf("out_tvalid[%0d]", k), 1'b0, out_tvalid[k]);
        end
        check_count("drop_count", '0, drop_count);

        for (int p = 0; p < PACKETS; p++) begin
            for (int b = 0; b < tbl_len[p]; b++) begin
                send_beat(tbl_data[p] + data_t'(b),
                          (b == 0) ? tbl_dest[p] : dest_t'($random(seed)),
                          b == tbl_len[p] - 1);
            end
        end
        in_tvalid = 1'b0;
        in_tlast  = 1'b0;

        while (!outputs_drained()) begin
            @(negedge aclk);
        end
        repeat (3) @(negedge aclk);              // Dropped beats clear unit 1 within two edges
        check_count("drop_count", exp_drops, drop_count);
        $display("all tests passed");
        $finish;
    end

endmodule

// File: src.f
design/stream_demux_pkg.sv
design/stream_route_fsm.sv
design/stream_demux_unit.sv
design/stream_drop_counter.sv
design/stream_demux_top.sv
bench/stream_demux_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the stream demux testbench with Verilator and runs it.
# The exit status of the simulation is the result of the run.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module stream_demux_tb \
    --Mdir obj_dir -o stream_demux_sim \
    -f src.f

./obj_dir/stream_demux_sim
